//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module game_tb -o game_sim
	./obj_dir/game_sim | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- hdl/game_pkg.sv
package game_pkg;

    // key-down vector layout.
    localparam int KEY_COUNT = 10;

    // player 2 keys.
    localparam int KEY_W = 0;
    localparam int KEY_A = 1;
    localparam int KEY_S = 2;
    localparam int KEY_D = 3;
    // player 1 keys, arrow cluster.
    localparam int KEY_UP = 4;
    localparam int KEY_LEFT = 5;
    localparam int KEY_DOWN = 6;
    localparam int KEY_RIGHT = 7;
    localparam int KEY_ENTER = 8; // menu start.

    typedef logic [KEY_COUNT-1:0] key_vec_t;

    // one player's held keys.
    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
    } player_keys_t;

    // sprite codes of the drawn pose.
    typedef enum logic [3:0] {
        POSE_STATIC = 4'd6,
        POSE_LEFT = 4'd2,
        POSE_UP = 4'd8,
        POSE_RIGHT = 4'd7
    } pose_t;

    typedef enum logic [1:0] {
        JUMP_IDLE = 2'd0,
        JUMP_RISE = 2'd1,
        JUMP_FALL = 2'd2
    } jump_phase_t;

    // player_ctrl to jump_timer.
    typedef enum logic [1:0] {
        CMD_HOLD = 2'd0,  // keep phase and count.
        CMD_CLEAR = 2'd1, // idle, count 0.
        CMD_STEP = 2'd2,  // advance the jump.
        CMD_STOP = 2'd3   // drop an unsustained jump.
    } jump_cmd_t;

    typedef struct packed {
        pose_t pose;
        jump_phase_t phase;
    } player_status_t;

    // menu, or the level being played.
    typedef enum logic [2:0] {
        MODE_MENU = 3'd0,
        MODE_LEVEL_1 = 3'd1,
        MODE_LEVEL_2 = 3'd2,
        MODE_LEVEL_3 = 3'd3,
        MODE_LEVEL_4 = 3'd4,
        MODE_LEVEL_5 = 3'd5
    } game_mode_t;

    typedef logic [2:0] level_t;

    // board values, one second per phase at 50 MHz.
    localparam int DEF_LEVEL_COUNT = 5;
    localparam int DEF_RISE_CYCLES = 50_000_000;
    localparam int DEF_FALL_CYCLES = 50_000_000;

endpackage

//--- hdl/game_top.sv
`timescale 1ns/1ps

module game_top #(
    parameter int LEVEL_COUNT = game_pkg::DEF_LEVEL_COUNT,
    parameter int RISE_CYCLES = game_pkg::DEF_RISE_CYCLES,
    parameter int FALL_CYCLES = game_pkg::DEF_FALL_CYCLES
) (
    input logic clk,
    input logic rst,
    input game_pkg::key_vec_t key_down,
    input logic p1_collide,
    input logic p2_collide,
    output game_pkg::game_mode_t mode,
    output game_pkg::level_t level,
    output game_pkg::player_status_t p1_status,
    output game_pkg::player_status_t p2_status
);
    import game_pkg::*;

    player_keys_t p1_keys;
    player_keys_t p2_keys;
    logic in_game;

    // player 1 on the arrows.
    assign p1_keys = '{
        up: key_down[KEY_UP],
        left: key_down[KEY_LEFT],
        down: key_down[KEY_DOWN],
        right: key_down[KEY_RIGHT]
    };
    // player 2 on WASD.
    assign p2_keys = '{
        up: key_down[KEY_W],
        left: key_down[KEY_A],
        down: key_down[KEY_S],
        right: key_down[KEY_D]
    };

    assign in_game = (mode != MODE_MENU);

    level_menu #(
        .LEVEL_COUNT(LEVEL_COUNT)
    ) u_level_menu (
        .clk(clk),
        .rst(rst),
        .key_down(key_down), // menu sees every key.
        .mode(mode),
        .level(level)
    );

    player_ctrl #(
        .RISE_CYCLES(RISE_CYCLES),
        .FALL_CYCLES(FALL_CYCLES)
    ) u_player1 (
        .clk(clk),
        .rst(rst),
        .keys(p1_keys),
        .in_game(in_game),
        .collide(p1_collide),
        .status(p1_status)
    );

    player_ctrl #(
        .RISE_CYCLES(RISE_CYCLES),
        .FALL_CYCLES(FALL_CYCLES)
    ) u_player2 (
        .clk(clk),
        .rst(rst),
        .keys(p2_keys),
        .in_game(in_game),
        .collide(p2_collide),
        .status(p2_status)
    );

endmodule

//--- hdl/jump_timer.sv
`timescale 1ns/1ps

module jump_timer #(
    parameter int RISE_CYCLES = game_pkg::DEF_RISE_CYCLES,
    parameter int FALL_CYCLES = game_pkg::DEF_FALL_CYCLES
) (
    input logic clk,
    input logic rst,
    input game_pkg::jump_cmd_t cmd,
    input logic collide,
    output game_pkg::jump_phase_t phase
);
    import game_pkg::*;

    // count runs 0 to TOTAL inclusive.
    localparam int TOTAL_CYCLES = RISE_CYCLES + FALL_CYCLES;
    localparam int CNT_W = $clog2(TOTAL_CYCLES + 1);
    localparam logic [CNT_W-1:0] RISE_END = CNT_W'(RISE_CYCLES);
    localparam logic [CNT_W-1:0] TOTAL_END = CNT_W'(TOTAL_CYCLES);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_d;
    jump_phase_t phase_d;

    logic done;     // jump has run its full length.
    logic can_rise; // still inside the rise window.

    assign done = (count >= TOTAL_END);
    // a collision or an earlier fall ends the rise for good.
    assign can_rise = (count < RISE_END) && !collide && (phase != JUMP_FALL);

    always_comb begin
        phase_d = phase;
        count_d = count;
        case (cmd)
            CMD_CLEAR: begin
                phase_d = JUMP_IDLE;
                count_d = '0;
            end
            CMD_STEP: begin
                if (done) begin
                    // wrap and land together, next step starts a rise.
                    phase_d = JUMP_IDLE;
                    count_d = '0;
                end else if (can_rise) begin
                    phase_d = JUMP_RISE;
                    count_d = count + 1'b1;
                end else begin
                    phase_d = JUMP_FALL;
                    count_d = count + 1'b1;
                end
            end
            CMD_STOP: begin
                phase_d = JUMP_IDLE;
                if (done) count_d = '0; // otherwise count holds.
            end
            default: ; // CMD_HOLD.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= JUMP_IDLE;
            count <= '0;
        end else begin
            phase <= phase_d;
            count <= count_d;
        end
    end

endmodule

//--- hdl/level_menu.sv
`timescale 1ns/1ps

module level_menu #(
    parameter int LEVEL_COUNT = game_pkg::DEF_LEVEL_COUNT
) (
    input logic clk,
    input logic rst,
    input game_pkg::key_vec_t key_down,
    output game_pkg::game_mode_t mode,
    output game_pkg::level_t level
);
    import game_pkg::*;

    localparam level_t LEVEL_MIN = 3'd1;
    localparam level_t LEVEL_MAX = level_t'(LEVEL_COUNT);

    logic armed; // cleared by a step, set again on full release.

    game_mode_t mode_d;
    level_t level_d;
    logic armed_d;

    logic up_key;
    logic down_key;
    logic any_key;

    // W and UP both raise, S and DOWN both lower.
    assign up_key = key_down[KEY_W] | key_down[KEY_UP];
    assign down_key = key_down[KEY_S] | key_down[KEY_DOWN];
    assign any_key = |key_down;

    always_comb begin
        mode_d = mode;
        level_d = level;
        armed_d = armed;
        if (mode == MODE_MENU) begin
            if (!any_key) begin
                armed_d = 1'b1; // all released.
            end else if (armed) begin
                // priority follows the key order below.
                if (up_key) begin
                    if (level < LEVEL_MAX) level_d = level + 3'd1;
                    armed_d = 1'b0;
                end else if (down_key) begin
                    if (level > LEVEL_MIN) level_d = level - 3'd1;
                    armed_d = 1'b0;
                end else if (key_down[KEY_ENTER]) begin
                    mode_d = game_mode_t'(level); // start the chosen level.
                end
                // other keys are ignored here.
            end
        end else begin
            // in game the selection is frozen.
            armed_d = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= MODE_MENU;
            level <= LEVEL_MIN;
            armed <= 1'b1;
        end else begin
            mode <= mode_d;
            level <= level_d;
            armed <= armed_d;
        end
    end

endmodule

//--- hdl/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl #(
    parameter int RISE_CYCLES = game_pkg::DEF_RISE_CYCLES,
    parameter int FALL_CYCLES = game_pkg::DEF_FALL_CYCLES
) (
    input logic clk,
    input logic rst,
    input game_pkg::player_keys_t keys,
    input logic in_game,
    input logic collide,
    output game_pkg::player_status_t status
);
    import game_pkg::*;

    pose_t pose;
    pose_t pose_d;
    jump_cmd_t jump_cmd;
    jump_phase_t jump_phase;

    logic jumping;
    logic no_key;
    logic up_only;
    logic go_left;
    logic go_right;

    assign jumping = (jump_phase != JUMP_IDLE);
    assign no_key = !(keys.up | keys.left | keys.down | keys.right);
    assign up_only = keys.up && !keys.left && !keys.down && !keys.right;
    // up counts toward either side unless the opposite side is held.
    assign go_left = (keys.left || keys.up) && !keys.right;
    assign go_right = (keys.right || keys.up) && !keys.left;

    // key priority, first match wins.
    always_comb begin
        pose_d = pose;
        jump_cmd = CMD_HOLD; // menu freezes everything.
        if (in_game) begin
            if (no_key) begin
                if (!jumping) begin
                    pose_d = POSE_STATIC;
                    jump_cmd = CMD_CLEAR;
                end else begin
                    jump_cmd = CMD_STEP; // finish the jump in the air.
                end
            end else if (up_only) begin
                pose_d = POSE_UP;
                jump_cmd = CMD_STEP;
            end else if (go_left) begin
                pose_d = POSE_LEFT;
                jump_cmd = (keys.up || jumping) ? CMD_STEP : CMD_STOP;
            end else if (go_right) begin
                pose_d = POSE_RIGHT;
                jump_cmd = (keys.up || jumping) ? CMD_STEP : CMD_STOP;
            end else begin
                // both sides, or down alone. pose holds.
                jump_cmd = jumping ? CMD_STEP : CMD_HOLD;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pose <= POSE_STATIC;
        end else begin
            pose <= pose_d;
        end
    end

    jump_timer #(
        .RISE_CYCLES(RISE_CYCLES),
        .FALL_CYCLES(FALL_CYCLES)
    ) u_jump_timer (
        .clk(clk),
        .rst(rst),
        .cmd(jump_cmd),
        .collide(collide),
        .phase(jump_phase)
    );

    // both fields come straight from registers.
    assign status = '{pose: pose, phase: jump_phase};

endmodule

//--- sim.f
hdl/game_pkg.sv
hdl/jump_timer.sv
hdl/player_ctrl.sv
hdl/level_menu.sv
hdl/game_top.sv
test/game_sva.sv
test/game_checker.sv
test/game_tb.sv

//--- test/game_checker.sv
`timescale 1ns/1ps

module game_checker #(
    parameter int LEVEL_COUNT = 5,
    parameter int RISE = 12,
    parameter int FALL = 9
) (
    input logic clk,
    input logic rst,
    input game_pkg::key_vec_t key_down,
    input logic p1_collide,
    input logic p2_collide,
    input game_pkg::game_mode_t mode,
    input game_pkg::level_t level,
    input game_pkg::player_status_t p1_status,
    input game_pkg::player_status_t p2_status,
    output int errors
);
    import game_pkg::*;

    typedef struct packed {
        game_mode_t mode;
        level_t level;
        logic armed;
    } menu_ref_t;

    typedef struct packed {
        pose_t pose;
        jump_phase_t phase;
        int count; // cycles into the jump.
    } player_ref_t;

    menu_ref_t menu_ref;
    player_ref_t p1_ref;
    player_ref_t p2_ref;
    player_keys_t p1_keys;
    player_keys_t p2_keys;
    logic model_valid = 1'b0; // set by the first reset.
    int error_count = 0;

    assign errors = error_count;

    // arrows for player 1, WASD for player 2.
    assign p1_keys = {key_down[KEY_UP], key_down[KEY_LEFT], key_down[KEY_DOWN], key_down[KEY_RIGHT]};
    assign p2_keys = {key_down[KEY_W], key_down[KEY_A], key_down[KEY_S], key_down[KEY_D]};

    // expected menu state one clock later.
    function automatic menu_ref_t menu_next(menu_ref_t s, key_vec_t k);
        menu_ref_t n;
        n = s;
        if (s.mode != MODE_MENU || k == '0) begin
            n.armed = 1'b1; // released, or already in game.
        end else if (s.armed) begin
            if (k[KEY_W] || k[KEY_UP]) begin
                n.level = (s.level == level_t'(LEVEL_COUNT)) ? s.level : s.level + 3'd1;
                n.armed = 1'b0;
            end else if (k[KEY_S] || k[KEY_DOWN]) begin
                n.level = (s.level == 3'd1) ? s.level : s.level - 3'd1;
                n.armed = 1'b0;
            end else if (k[KEY_ENTER]) begin
                n.mode = game_mode_t'(s.level);
            end
        end
        return n;
    endfunction

    // jump phase and count after one command.
    function automatic player_ref_t jump_next(player_ref_t s, jump_cmd_t cmd, logic collide);
        player_ref_t n;
        n = s;
        if (cmd == CMD_CLEAR) begin
            n.phase = JUMP_IDLE;
            n.count = 0;
        end else if (cmd == CMD_STOP) begin
            n.phase = JUMP_IDLE;
            if (s.count >= RISE + FALL) n.count = 0;
        end else if (cmd == CMD_STEP) begin
            if (s.count >= RISE + FALL) begin
                n.phase = JUMP_IDLE; // landed, count wraps.
                n.count = 0;
            end else begin
                n.count = s.count + 1;
                if (s.count < RISE && !collide && s.phase != JUMP_FALL) n.phase = JUMP_RISE;
                else n.phase = JUMP_FALL;
            end
        end
        return n;
    endfunction

    // key priority of one player, then the timer.
    function automatic player_ref_t player_next(player_ref_t s, player_keys_t k,
                                                logic in_game, logic collide);
        player_ref_t n;
        jump_cmd_t cmd;
        logic air;
        n = s;
        cmd = CMD_HOLD;
        air = (s.phase != JUMP_IDLE);
        if (in_game) begin
            if (!(k.up || k.left || k.down || k.right)) begin
                cmd = air ? CMD_STEP : CMD_CLEAR;
                if (!air) n.pose = POSE_STATIC;
            end else if (k.up && !k.left && !k.down && !k.right) begin
                n.pose = POSE_UP;
                cmd = CMD_STEP;
            end else if ((k.left || k.up) && !k.right) begin
                n.pose = POSE_LEFT;
                cmd = (k.up || air) ? CMD_STEP : CMD_STOP;
            end else if ((k.right || k.up) && !k.left) begin
                n.pose = POSE_RIGHT;
                cmd = (k.up || air) ? CMD_STEP : CMD_STOP;
            end else begin
                cmd = air ? CMD_STEP : CMD_HOLD; // pose holds.
            end
        end
        return jump_next(n, cmd, collide);
    endfunction

    // inputs are stable at the edge.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            menu_ref <= '{mode: MODE_MENU, level: 3'd1, armed: 1'b1};
            p1_ref <= '{pose: POSE_STATIC, phase: JUMP_IDLE, count: 0};
            p2_ref <= '{pose: POSE_STATIC, phase: JUMP_IDLE, count: 0};
            model_valid <= 1'b1;
        end else begin
            menu_ref <= menu_next(menu_ref, key_down);
            p1_ref <= player_next(p1_ref, p1_keys, menu_ref.mode != MODE_MENU, p1_collide);
            p2_ref <= player_next(p2_ref, p2_keys, menu_ref.mode != MODE_MENU, p2_collide);
        end
    end

    task automatic check_field(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // outputs settled half a cycle after the edge.
    always @(negedge clk) begin
        if (model_valid) begin
            check_field("mode", 8'(mode), 8'(menu_ref.mode));
            check_field("level", 8'(level), 8'(menu_ref.level));
            check_field("p1_status.pose", 8'(p1_status.pose), 8'(p1_ref.pose));
            check_field("p1_status.phase", 8'(p1_status.phase), 8'(p1_ref.phase));
            check_field("p2_status.pose", 8'(p2_status.pose), 8'(p2_ref.pose));
            check_field("p2_status.phase", 8'(p2_status.phase), 8'(p2_ref.phase));
        end
    end

endmodule

//--- test/game_sva.sv
`timescale 1ns/1ps

module game_sva (
    input logic clk,
    input logic rst,
    input logic in_game,
    input game_pkg::pose_t pose,
    input game_pkg::jump_cmd_t cmd,
    input game_pkg::jump_phase_t phase
);
    import game_pkg::*;

    int failures = 0; // failed checks of this instance.

    // the menu freezes the pose.
    pose_only_in_game: assert property (@(posedge clk) disable iff (rst)
        !$stable(pose) |-> $past(in_game))
        else begin
            $error("pose changed while in the menu");
            failures++;
        end

    // a cut-off rise never resumes.
    no_fall_to_rise: assert property (@(posedge clk) disable iff (rst)
        (phase == JUMP_RISE) |-> ($past(phase) != JUMP_FALL))
        else begin
            $error("phase went from fall straight to rise");
            failures++;
        end

    clear_gives_idle: assert property (@(posedge clk) disable iff (rst)
        ($past(cmd) == CMD_CLEAR) |-> (phase == JUMP_IDLE))
        else begin
            $error("phase not idle after a clear command");
            failures++;
        end

endmodule

bind player_ctrl game_sva u_sva (
    .clk(clk),
    .rst(rst),
    .in_game(in_game),
    .pose(pose),
    .cmd(jump_cmd),
    .phase(jump_phase)
);

//--- test/game_tb.sv
`timescale 1ns/1ps

module game_tb #(
    parameter int RISE = 12,
    parameter int FALL = 9,
    parameter int LEVEL_COUNT = 5
);
    import game_pkg::*;

    logic clk = 1'b0;
    logic rst = 1'b1;
    key_vec_t key_down = '0;
    logic p1_collide = 1'b0;
    logic p2_collide = 1'b0;
    game_mode_t mode;
    level_t level;
    player_status_t p1_status;
    player_status_t p2_status;

    int seed = 32'h4f92670e;
    int mismatches; // counted by the checker.
    int timeouts = 0;
    int assert_failures = 0; // summed over both players.
    int n;
    int hold;
    key_vec_t k;

    always #50 clk = ~clk; // 100 ns period.

    game_top #(
        .LEVEL_COUNT(LEVEL_COUNT),
        .RISE_CYCLES(RISE),
        .FALL_CYCLES(FALL)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .key_down(key_down),
        .p1_collide(p1_collide),
        .p2_collide(p2_collide),
        .mode(mode),
        .level(level),
        .p1_status(p1_status),
        .p2_status(p2_status)
    );

    game_checker #(
        .LEVEL_COUNT(LEVEL_COUNT),
        .RISE(RISE),
        .FALL(FALL)
    ) u_checker (
        .clk(clk),
        .rst(rst),
        .key_down(key_down),
        .p1_collide(p1_collide),
        .p2_collide(p2_collide),
        .mode(mode),
        .level(level),
        .p1_status(p1_status),
        .p2_status(p2_status),
        .errors(mismatches)
    );

    function automatic key_vec_t key_mask(int idx);
        return key_vec_t'(1) << idx;
    endfunction

    function automatic jump_phase_t phase_of(int p);
        return (p == 1) ? p1_status.phase : p2_status.phase;
    endfunction

    // inputs change 5 ns after the edge.
    task automatic drive(key_vec_t keys, logic c1, logic c2);
        @(posedge clk);
        #5;
        key_down = keys;
        p1_collide = c1;
        p2_collide = c2;
    endtask

    task automatic tap(key_vec_t keys);
        drive(keys, 1'b0, 1'b0);
        drive('0, 1'b0, 1'b0); // release re-arms the menu.
    endtask

    task automatic wait_phase(int p, jump_phase_t ph, int limit);
        int i;
        i = 0;
        do begin
            @(negedge clk);
            i++;
        end while (phase_of(p) != ph && i < limit);
        if (phase_of(p) != ph) begin
            $display("timeout: player %0d did not reach phase %s", p, ph.name());
            timeouts++;
        end
    endtask

    initial begin
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        // a held UP steps only once.
        repeat (6) drive(key_mask(KEY_UP), 1'b0, 1'b0);
        drive('0, 1'b0, 1'b0);
        n = 0;
        while (level != level_t'(LEVEL_COUNT) && n < 2 * LEVEL_COUNT) begin
            tap(key_mask(KEY_W));
            n++;
        end
        if (level != level_t'(LEVEL_COUNT)) begin
            $display("timeout: level never reached the top");
            timeouts++;
        end
        tap(key_mask(KEY_W)); // saturates.
        n = 0;
        while (level != 3'd1 && n < 2 * LEVEL_COUNT) begin
            tap(key_mask(n[0] ? KEY_S : KEY_DOWN));
            n++;
        end
        if (level != 3'd1) begin
            $display("timeout: level never returned to 1");
            timeouts++;
        end
        tap(key_mask(KEY_DOWN));
        tap(key_mask(KEY_UP));
        tap(key_mask(KEY_W));
        // player keys in the menu, poses must stay static.
        tap(key_mask(KEY_LEFT) | key_mask(KEY_D));
        tap(key_mask(KEY_RIGHT));
        drive(key_mask(KEY_ENTER), 1'b0, 1'b0);
        n = 0;
        while (mode == MODE_MENU && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (mode == MODE_MENU) begin
            $display("timeout: ENTER did not start the game");
            timeouts++;
        end
        drive('0, 1'b0, 1'b0);
        // full jump for player 1.
        drive(key_mask(KEY_UP), 1'b0, 1'b0);
        wait_phase(1, JUMP_RISE, 4);
        wait_phase(1, JUMP_FALL, RISE + 2);
        wait_phase(1, JUMP_IDLE, FALL + 2);
        wait_phase(1, JUMP_RISE, 3);
        // collision pulse cuts player 2's rise.
        drive(key_mask(KEY_W), 1'b0, 1'b0);
        wait_phase(2, JUMP_RISE, 4);
        drive(key_mask(KEY_W), 1'b0, 1'b1);
        drive(key_mask(KEY_W), 1'b0, 1'b0);
        wait_phase(2, JUMP_FALL, 2);
        drive('0, 1'b0, 1'b0);
        wait_phase(2, JUMP_IDLE, RISE + FALL + 4);
        tap(key_mask(KEY_A)); // grounded left tap.
        // reset again, random keys from the menu on.
        drive('0, 1'b0, 1'b0);
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        repeat (300) begin
            k = key_vec_t'($random(seed) & $random(seed) & $random(seed));
            hold = 1 + ($random(seed) & 3);
            repeat (hold) drive(k, ($random(seed) & 7) == 0, ($random(seed) & 7) == 0);
        end
        drive('0, 1'b0, 1'b0);
        repeat (3) @(negedge clk);
        assert_failures = UUT.u_player1.u_sva.failures + UUT.u_player2.u_sva.failures;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_failures);
        if (mismatches == 0 && timeouts == 0 && assert_failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
